/* Bender.yml */
package:
  name: sram_io_if

sources:
  - sram_pkg.sv
  - sync_fifo.sv
  - sram_io_pads.sv
  - sram_io_if.sv
  - target: simulation
    files:
      - async_sram_model.sv
      - tb_sram_io_if.sv

/* async_sram_model.sv */
`timescale 1ns/10ps

module async_sram_model
  import sram_pkg::*;
(
  input  sram_addr_t sram_addr,
  inout  wire sram_data_t sram_data,
  input  logic       sram_we_n,
  input  logic       sram_oe_n,
  input  logic       sram_ce_n
);

  sram_data_t mem[2**SRAM_ADDR_W];

  // set while both we_n and ce_n are low
  logic write_armed;

  initial begin
    for (int i = 0; i < 2**SRAM_ADDR_W; i++) begin
      mem[i] = '0;
    end
    write_armed = 1'b0;
  end

  // read data appears as soon as the chip is selected with oe low
  assign sram_data = (!sram_ce_n && !sram_oe_n) ? mem[sram_addr] : 'z;

  // store on the we_n rise, even if ce_n rises in the same step
  always @(sram_we_n or sram_ce_n) begin
    if (!sram_we_n && !sram_ce_n) begin
      write_armed = 1'b1;
    end else if (write_armed && sram_we_n) begin
      mem[sram_addr] = sram_data;
      write_armed = 1'b0;
    end
  end

endmodule

/* sram_io_if.f */
sram_pkg.sv
sync_fifo.sv
sram_io_pads.sv
sram_io_if.sv
async_sram_model.sv
tb_sram_io_if.sv

/* sram_io_if.sv */
`timescale 1ns/10ps

module sram_io_if
  import sram_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // command port
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  sram_addr_t cmd_addr,
  input  logic       cmd_wr_en,
  input  sram_data_t cmd_wr_data,

  // read response port
  output logic       resp_valid,
  input  logic       resp_ready,
  output sram_data_t resp_data,

  // chip pins
  output sram_addr_t sram_addr,
  inout  wire sram_data_t sram_data,
  output logic       sram_we_n,
  output logic       sram_oe_n,
  output logic       sram_ce_n
);

  ctrl_state_t state;
  ctrl_state_t state_next;

  // pad request registers
  sram_addr_t pad_addr;
  logic       pad_wr_en;
  sram_data_t pad_wr_data;
  logic       pad_we_n;
  logic       pad_oe_n;

  // read return from the pads
  sram_data_t pad_rd_data;
  logic       pad_rd_valid;

  // response queue status
  logic fifo_half_full;
  logic fifo_empty;

  logic cmd_fire;
  logic resp_fire;

  // stop taking commands once the queue is half full,
  // reads already at the pads still fit in the other half
  assign cmd_ready = (state == ST_IDLE) && !fifo_half_full;
  assign cmd_fire  = cmd_valid && cmd_ready;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (cmd_fire) begin
          state_next = cmd_wr_en ? ST_WRITE : ST_READ;
        end
      end
      ST_READ: begin
        state_next = ST_IDLE;
      end
      ST_WRITE: begin
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // capture address and data on acceptance
  always_ff @(posedge clk) begin
    if (state_next != ST_IDLE) begin
      pad_addr <= cmd_addr;
    end
    if (state_next == ST_WRITE) begin
      pad_wr_data <= cmd_wr_data;
    end
  end

  // strobes follow the next state so they line up with addr and data
  // write enable stays one extra cycle to hold data past the we_n rise
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pad_we_n  <= 1'b1;
      pad_oe_n  <= 1'b1;
      pad_wr_en <= 1'b0;
    end else begin
      pad_we_n  <= (state_next != ST_WRITE);
      pad_oe_n  <= (state_next != ST_READ);
      pad_wr_en <= (state_next == ST_WRITE) || (state == ST_WRITE);
    end
  end

  sram_io_pads u_pads (
    .clk         (clk),
    .rst_n       (rst_n),
    .pad_addr    (pad_addr),
    .pad_wr_en   (pad_wr_en),
    .pad_wr_data (pad_wr_data),
    .pad_we_n    (pad_we_n),
    .pad_oe_n    (pad_oe_n),
    .pad_rd_data (pad_rd_data),
    .pad_rd_valid(pad_rd_valid),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_ce_n   (sram_ce_n)
  );

  // read results in command order
  sync_fifo #(
    .ADDR_W(RESP_FIFO_ADDR_W)
  ) u_resp_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .clr        (1'b0),
    .w_inc      (pad_rd_valid),
    .w_data     (pad_rd_data),
    .w_full     (),
    .w_half_full(fifo_half_full),
    .r_inc      (resp_fire),
    .r_data     (resp_data),
    .r_empty    (fifo_empty)
  );

  assign resp_valid = !fifo_empty;
  assign resp_fire  = resp_valid && resp_ready;

endmodule

/* sram_io_pads.sv */
`timescale 1ns/10ps

module sram_io_pads
  import sram_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // request side, all registered upstream
  input  sram_addr_t pad_addr,
  input  logic       pad_wr_en,
  input  sram_data_t pad_wr_data,
  input  logic       pad_we_n,
  input  logic       pad_oe_n,

  // read return, one cycle pulse
  output sram_data_t pad_rd_data,
  output logic       pad_rd_valid,

  // chip pins
  output sram_addr_t sram_addr,
  inout  wire sram_data_t sram_data,
  output logic       sram_we_n,
  output logic       sram_oe_n,
  output logic       sram_ce_n
);

  // output flops for the data bus
  sram_data_t wr_data_q;
  logic       wr_en_q;

  // input flop, samples the bus every cycle
  sram_data_t rd_data_in;

  // oe active, delayed to line up with the input flop
  logic oe_act_q1;
  logic oe_act_q2;

  // address and write data out, no reset
  always_ff @(posedge clk) begin
    sram_addr <= pad_addr;
    wr_data_q <= pad_wr_data;
  end

  // strobes come out of reset inactive
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_ce_n <= 1'b1;
      wr_en_q   <= 1'b0;
    end else begin
      sram_we_n <= pad_we_n;
      sram_oe_n <= pad_oe_n;
      // chip enabled whenever either strobe is active
      sram_ce_n <= pad_we_n & pad_oe_n;
      wr_en_q   <= pad_wr_en;
    end
  end

  // drive the bus only for a write, released otherwise
  assign sram_data = wr_en_q ? wr_data_q : 'z;

  // oe goes low on the pins one edge after the request,
  // the bus is sampled on the edge after that
  always_ff @(posedge clk) begin
    rd_data_in <= sram_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      oe_act_q1    <= 1'b0;
      oe_act_q2    <= 1'b0;
      pad_rd_valid <= 1'b0;
    end else begin
      oe_act_q1    <= !pad_oe_n;
      oe_act_q2    <= oe_act_q1;
      pad_rd_valid <= oe_act_q2;
    end
  end

  // hand the sampled word over together with the valid pulse
  always_ff @(posedge clk) begin
    if (oe_act_q2) begin
      pad_rd_data <= rd_data_in;
    end
  end

endmodule

/* sram_pkg.sv */
package sram_pkg;

  // word address into the external chip
  localparam int SRAM_ADDR_W = 8;

  // one full data word, no byte lanes
  localparam int SRAM_DATA_W = 16;

  // response queue pointer width, 8 entries
  // half full at 4 still leaves room for every read already at the pads
  localparam int RESP_FIFO_ADDR_W = 3;

  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

  typedef logic [SRAM_DATA_W-1:0] sram_data_t;

  // command controller states
  // read and write each last a single cycle
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_READ  = 2'd1,
    ST_WRITE = 2'd2
  } ctrl_state_t;

endpackage

/* sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo
  import sram_pkg::*;
#(
  parameter int ADDR_W = RESP_FIFO_ADDR_W
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clr,

  input  logic       w_inc,
  input  sram_data_t w_data,
  output logic       w_full,
  output logic       w_half_full,

  input  logic       r_inc,
  output sram_data_t r_data,
  output logic       r_empty
);

  // storage, no reset needed
  sram_data_t mem[2**ADDR_W];

  // extra msb tells full from empty
  logic [ADDR_W:0] w_ptr;
  logic [ADDR_W:0] r_ptr;
  logic [ADDR_W:0] count;

  logic do_write;
  logic do_read;

  assign count = w_ptr - r_ptr;

  assign r_empty = (w_ptr == r_ptr);

  // count never exceeds the depth, so the msb alone means full
  assign w_full = count[ADDR_W];

  // at or above half the depth
  assign w_half_full = count[ADDR_W] | count[ADDR_W-1];

  assign do_write = w_inc && !w_full;
  assign do_read  = r_inc && !r_empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
    end else if (clr) begin
      w_ptr <= '0;
    end else if (do_write) begin
      w_ptr <= w_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_ptr <= '0;
    end else if (clr) begin
      r_ptr <= '0;
    end else if (do_read) begin
      r_ptr <= r_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[w_ptr[ADDR_W-1:0]] <= w_data;
    end
  end

  // head of queue, shown without a read cycle
  assign r_data = mem[r_ptr[ADDR_W-1:0]];

endmodule

/* tb_sram_io_if.sv */
`timescale 1ns/10ps

module tb_sram_io_if
  import sram_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam logic [31:0] SEED = 32'h927d;
  // 17 write/read, 3 latency, 16 back-pressure, 200 random
  localparam int NUM_CMDS = 236;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 10 + 200;

  localparam int DRAIN_HOLD   = 0;
  localparam int DRAIN_ALWAYS = 1;
  localparam int DRAIN_RANDOM = 2;

  logic       clk;
  logic       rst_n;
  logic       cmd_valid;
  logic       cmd_ready;
  sram_addr_t cmd_addr;
  logic       cmd_wr_en;
  sram_data_t cmd_wr_data;
  logic       resp_valid;
  logic       resp_ready;
  sram_data_t resp_data;
  sram_addr_t sram_addr;
  wire sram_data_t sram_data;
  logic       sram_we_n;
  logic       sram_oe_n;
  logic       sram_ce_n;

  // reference copy of the chip and the reads still owed
  sram_data_t ref_mem[2**SRAM_ADDR_W];
  sram_data_t exp_q[$];

  int value_errors;
  int other_errors;
  int reads_accepted;
  int drain_mode;
  logic [31:0] seed_dummy;

  sram_io_if uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_addr   (cmd_addr),
    .cmd_wr_en  (cmd_wr_en),
    .cmd_wr_data(cmd_wr_data),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_data  (resp_data),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

  async_sram_model u_chip (
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n),
    .sram_ce_n(sram_ce_n)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_data(input string name, input sram_data_t exp, input sram_data_t act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_addr(input string name, input sram_addr_t exp, input sram_addr_t act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_cmd(input logic wr, input sram_addr_t addr, input sram_data_t data);
    cmd_valid   = 1'b1;
    cmd_wr_en   = wr;
    cmd_addr    = addr;
    cmd_wr_data = data;
    while (!cmd_ready) begin
      @(negedge clk);
    end
    // ready high here, so the next rising edge takes the command
    if (wr) begin
      ref_mem[addr] = data;
    end else begin
      exp_q.push_back(ref_mem[addr]);
      reads_accepted++;
    end
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic take_resp();
    sram_data_t expected;
    if (exp_q.size() == 0) begin
      other_errors++;
      $display("a response came out with no read outstanding, data 0x%h", resp_data);
    end else begin
      expected = exp_q.pop_front();
      check_data("resp_data", expected, resp_data);
    end
  endtask

  // drives resp_ready and takes responses
  always @(negedge clk) begin
    if (rst_n) begin
      case (drain_mode)
        DRAIN_HOLD:   resp_ready = 1'b0;
        DRAIN_RANDOM: resp_ready = ($urandom_range(0, 1) == 1);
        default:      resp_ready = 1'b1;
      endcase
      if (resp_ready && resp_valid) begin
        take_resp();
      end
    end
  end

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || resp_valid) && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d read responses never arrived", exp_q.size());
    end
    check_flag("resp_valid", 1'b0, resp_valid);
  endtask

  task automatic verify_reset_state();
    check_flag("cmd_ready", 1'b1, cmd_ready);
    check_flag("resp_valid", 1'b0, resp_valid);
    check_flag("sram_we_n", 1'b1, sram_we_n);
    check_flag("sram_oe_n", 1'b1, sram_oe_n);
    check_flag("sram_ce_n", 1'b1, sram_ce_n);
    check_data("sram_data", 'z, sram_data);
  endtask

  task automatic write_then_read_back();
    sram_addr_t addr;
    for (int i = 0; i < 8; i++) begin
      addr = sram_addr_t'(i * 29 + 5);
      send_cmd(1'b1, addr, sram_data_t'(16'ha5c3 ^ (i * 16'h1357)));
    end
    for (int i = 0; i < 8; i++) begin
      addr = sram_addr_t'(i * 29 + 5);
      send_cmd(1'b0, addr, '0);
    end
    // address never written reads as zero
    send_cmd(1'b0, 8'h02, '0);
    wait_drain();
  endtask

  task automatic measure_read_latency();
    sram_addr_t addr;
    send_cmd(1'b1, 8'h30, 16'h7e81);
    check_flag("cmd_ready", 1'b0, cmd_ready);
    // write strobe on the pins one edge after acceptance
    @(negedge clk);
    check_addr("sram_addr", 8'h30, sram_addr);
    check_flag("sram_we_n", 1'b0, sram_we_n);
    check_flag("sram_oe_n", 1'b1, sram_oe_n);
    check_flag("sram_ce_n", 1'b0, sram_ce_n);
    check_data("sram_data", 16'h7e81, sram_data);
    // data still on the bus for one cycle after we_n rises
    @(negedge clk);
    check_flag("sram_we_n", 1'b1, sram_we_n);
    check_flag("sram_ce_n", 1'b1, sram_ce_n);
    check_data("sram_data", 16'h7e81, sram_data);
    for (int r = 0; r < 2; r++) begin
      addr = 8'h30 + sram_addr_t'(r);
      send_cmd(1'b0, addr, '0);
      check_flag("cmd_ready", 1'b0, cmd_ready);
      check_flag("resp_valid", 1'b0, resp_valid);
      // read strobe on the pins one edge after acceptance
      @(negedge clk);
      check_flag("resp_valid", 1'b0, resp_valid);
      check_addr("sram_addr", addr, sram_addr);
      check_flag("sram_oe_n", 1'b0, sram_oe_n);
      check_flag("sram_we_n", 1'b1, sram_we_n);
      check_flag("sram_ce_n", 1'b0, sram_ce_n);
      repeat (2) begin
        @(negedge clk);
        check_flag("resp_valid", 1'b0, resp_valid);
      end
      // fourth edge after acceptance
      @(negedge clk);
      check_flag("resp_valid", 1'b1, resp_valid);
      wait_drain();
    end
  endtask

  task automatic stall_under_backpressure();
    int stall_run;
    int n;
    for (int i = 0; i < 8; i++) begin
      send_cmd(1'b1, 8'h80 + sram_addr_t'(i), 16'hc000 + sram_data_t'(i * 3));
    end
    drain_mode = DRAIN_HOLD;
    reads_accepted = 0;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          send_cmd(1'b0, 8'h80 + sram_addr_t'(i), '0);
        end
      end
      begin
        stall_run = 0;
        n = 0;
        // a single low cycle is the normal gap after acceptance
        while (stall_run < 3 && n < 100) begin
          @(negedge clk);
          n++;
          stall_run = cmd_ready ? 0 : stall_run + 1;
        end
        if (stall_run < 3) begin
          other_errors++;
          $display("cmd_ready never held low while the response queue filled");
        end
        if (reads_accepted < 4 || reads_accepted >= 8) begin
          other_errors++;
          $display("command port stalled after %0d reads instead of 4 to 7", reads_accepted);
        end
        check_flag("resp_valid", 1'b1, resp_valid);
        // let the reads still at the pads land
        repeat (8) @(negedge clk);
        drain_mode = DRAIN_ALWAYS;
      end
    join
    wait_drain();
  endtask

  task automatic random_mix();
    logic       wr;
    sram_addr_t addr;
    sram_data_t data;
    drain_mode = DRAIN_RANDOM;
    for (int i = 0; i < 200; i++) begin
      wr   = ($urandom_range(0, 1) == 1);
      addr = sram_addr_t'($urandom);
      data = sram_data_t'($urandom);
      send_cmd(wr, addr, data);
    end
    drain_mode = DRAIN_ALWAYS;
    wait_drain();
  endtask

  initial begin
    seed_dummy = $urandom(SEED);
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_addr    = '0;
    cmd_wr_en   = 1'b0;
    cmd_wr_data = '0;
    resp_ready  = 1'b0;
    drain_mode  = DRAIN_ALWAYS;
    value_errors   = 0;
    other_errors   = 0;
    reads_accepted = 0;
    for (int i = 0; i < 2**SRAM_ADDR_W; i++) begin
      ref_mem[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    verify_reset_state();
    write_then_read_back();
    measure_read_latency();
    stall_under_backpressure();
    random_mix();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule
